// File: hdl/sys_ctrl_pkg.sv
// System control shared definitions
package sys_ctrl_pkg;

	// Pixel and line dimensions
	localparam int DIM_W = 12;
	localparam int AR_W  = 13;

	////////////////////////////////
	// Host command codes
	////////////////////////////////
	localparam logic [7:0] CMD_CFG       = 8'h01;
	localparam logic [7:0] CMD_TIMING    = 8'h20;
	localparam logic [7:0] CMD_LED       = 8'h25;
	localparam logic [7:0] CMD_VSET      = 8'h27;
	localparam logic [7:0] CMD_HSET      = 8'h37;
	localparam logic [7:0] CMD_AR_CUSTOM = 8'h3A;

	// Greeting and protocol version
	localparam logic [23:0] MAGIC_PREFIX = 24'h5CA623;
	localparam logic [1:0]  IO_VER       = 2'd1;

	localparam logic [DIM_W-1:0] DEF_WIDTH  = 12'd1920;
	localparam logic [DIM_W-1:0] DEF_HEIGHT = 12'd1080;

	// Aspect word, index view applies when the partner word is zero
	typedef union packed {
		struct packed {
			logic             direct;
			logic [DIM_W-1:0] value;
		} ratio;
		logic [AR_W-1:0] index;
	} ar_word_u;

endpackage

// File: hdl/hps_strobe_sync.sv
// Host port strobe and acknowledge
`timescale 1ns/1ps

module hps_strobe_sync #(
	parameter logic [7:0] CORE_TYPE = 8'hA4
) (
	input  logic        clk_sys,
	input  logic        resetd,
	input  logic [31:0] i_gp_out,
	input  logic        i_io_wait,
	output logic [31:0] o_gp_in,
	output logic        o_io_strobe,
	output logic        o_io_uio,
	output logic [15:0] o_io_din
);
	import sys_ctrl_pkg::*;

	logic [31:0] gp_outd;
	logic [31:0] gp_outr;
	logic        io_clk;
	logic        io_strobe;
	logic        rack;
	logic        io_ack;
	logic        strobe_q;

	assign io_clk    = gp_outr[17];
	assign io_strobe = io_clk & ~rack;

	// ss1 low and ss2 high selects the user channel
	assign o_io_uio    = ~gp_outr[19] & gp_outr[20];
	assign o_io_din    = gp_outr[15:0];
	assign o_io_strobe = strobe_q;

	// Magic word until the host reports ready
	assign o_gp_in = gp_outr[31] ? {12'd0, IO_VER, io_ack, 17'd0} : {MAGIC_PREFIX, CORE_TYPE};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			gp_outd  <= '0;
			gp_outr  <= '0;
			rack     <= 1'b0;
			io_ack   <= 1'b0;
			strobe_q <= 1'b0;
		end else begin
			gp_outd <= i_gp_out;
			gp_outr <= gp_outd;
			// Hold the ack pair while the core asks for wait
			if (~i_io_wait | io_strobe) begin
				rack   <= io_clk;
				io_ack <= rack;
			end
			// Strobe already lasts one cycle since rack follows io_clk
			strobe_q <= io_strobe;
		end
	end

endmodule

// File: hdl/uio_cmd_decoder.sv
// User I/O command decoder
`timescale 1ns/1ps

module uio_cmd_decoder (
	input  logic                           clk_sys,
	input  logic                           resetd,
	input  logic                           i_io_strobe,
	input  logic                           i_io_uio,
	input  logic [15:0]                    i_io_din,
	input  logic [2:0]                     i_led_status,
	output logic [15:0]                    o_cfg,
	output logic [7:0]                     o_led,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_frame_width,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_frame_height,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_vset,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_hset,
	output logic                           o_freescale,
	output sys_ctrl_pkg::ar_word_u         o_arc1x,
	output sys_ctrl_pkg::ar_word_u         o_arc1y,
	output sys_ctrl_pkg::ar_word_u         o_arc2x,
	output sys_ctrl_pkg::ar_word_u         o_arc2y
);
	import sys_ctrl_pkg::*;

	logic [7:0] cmd;
	logic       has_cmd;
	logic [3:0] word_cnt;
	logic [7:0] led_overtake;
	logic [7:0] led_state;
	logic [7:0] led_base;

	// Power, disk and user on the even bits
	assign led_base = {3'b000, i_led_status[2], 1'b0, i_led_status[1], 1'b0, i_led_status[0]};

	////////////////////////////////
	// Command and data phases
	////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cmd            <= '0;
			has_cmd        <= 1'b0;
			word_cnt       <= '0;
			o_cfg          <= '0;
			led_overtake   <= '0;
			led_state      <= '0;
			o_frame_width  <= DEF_WIDTH;
			o_frame_height <= DEF_HEIGHT;
			o_vset         <= '0;
			o_hset         <= '0;
			o_freescale    <= 1'b0;
			o_arc1x        <= '0;
			o_arc1y        <= '0;
			o_arc2x        <= '0;
			o_arc2y        <= '0;
		end else if (!i_io_uio) begin
			has_cmd <= 1'b0;
		end else if (i_io_strobe) begin
			if (!has_cmd) begin
				has_cmd  <= 1'b1;
				cmd      <= i_io_din[7:0];
				word_cnt <= '0;
			end else begin
				// Saturate so long bursts do not wrap onto early words
				if (~&word_cnt) begin
					word_cnt <= word_cnt + 1'b1;
				end
				case (cmd)
					CMD_CFG: o_cfg <= i_io_din;
					CMD_TIMING: begin
						// Only active width and height are kept
						if (word_cnt == 4'd0) begin
							o_frame_width <= i_io_din[DIM_W-1:0];
						end else if (word_cnt == 4'd4) begin
							o_frame_height <= i_io_din[DIM_W-1:0];
						end
					end
					CMD_LED: {led_overtake, led_state} <= i_io_din;
					CMD_VSET: o_vset <= i_io_din[DIM_W-1:0];
					CMD_HSET: {o_freescale, o_hset} <= {i_io_din[15], i_io_din[DIM_W-1:0]};
					CMD_AR_CUSTOM: begin
						case (word_cnt)
							4'd0: o_arc1x <= i_io_din[AR_W-1:0];
							4'd1: o_arc1y <= i_io_din[AR_W-1:0];
							4'd2: o_arc2x <= i_io_din[AR_W-1:0];
							4'd3: o_arc2y <= i_io_din[AR_W-1:0];
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	// Main board LEDs
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_led <= '0;
		end else begin
			o_led <= (led_overtake & led_state) | (~led_overtake & led_base);
		end
	end

endmodule

// File: hdl/umuldiv.sv
// Sequential multiply then divide
`timescale 1ns/1ps

module umuldiv #(
	parameter int MD_W = sys_ctrl_pkg::DIM_W
) (
	input  logic            clk_sys,
	input  logic            resetd,
	input  logic            i_start,
	input  logic [MD_W-1:0] i_mul1,
	input  logic [MD_W-1:0] i_mul2,
	input  logic [MD_W-1:0] i_div,
	output logic            o_busy,
	output logic [MD_W-1:0] o_res
);
	localparam int CNT_W = $clog2(MD_W + 1);

	logic [2*MD_W-1:0] prod;
	logic [MD_W:0]     trial;
	logic [MD_W-1:0]   rem;
	logic [MD_W-1:0]   dvd;
	logic [MD_W-1:0]   dsr;
	logic [MD_W-1:0]   quo;
	logic [CNT_W-1:0]  bit_cnt;
	logic              overflow;

	assign prod     = i_mul1 * i_mul2;
	// Quotient does not fit, zero divisor lands here too
	assign overflow = prod[2*MD_W-1:MD_W] >= i_div;
	assign trial    = {rem, dvd[MD_W-1]};
	assign o_res    = quo;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy  <= 1'b0;
			bit_cnt <= '0;
		end else if (i_start) begin
			o_busy  <= ~overflow;
			bit_cnt <= CNT_W'(MD_W);
		end else if (o_busy) begin
			bit_cnt <= bit_cnt - 1'b1;
			if (bit_cnt == CNT_W'(1)) begin
				o_busy <= 1'b0;
			end
		end
	end

	////////////////////////////////
	// Restoring division, one bit per cycle
	////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			rem <= prod[2*MD_W-1:MD_W];
			dvd <= prod[MD_W-1:0];
			dsr <= i_div;
			quo <= overflow ? '1 : '0;
		end else if (o_busy) begin
			if (trial >= {1'b0, dsr}) begin
				rem <= MD_W'(trial - {1'b0, dsr});
				quo <= {quo[MD_W-2:0], 1'b1};
			end else begin
				rem <= trial[MD_W-1:0];
				quo <= {quo[MD_W-2:0], 1'b0};
			end
			dvd <= dvd << 1;
		end
	end

endmodule

// File: hdl/ar_window_calc.sv
// Aspect ratio display window
`timescale 1ns/1ps

module ar_window_calc #(
	parameter int MD_W = sys_ctrl_pkg::DIM_W
) (
	input  logic                           clk_sys,
	input  logic                           resetd,
	input  logic [sys_ctrl_pkg::DIM_W-1:0] i_frame_width,
	input  logic [sys_ctrl_pkg::DIM_W-1:0] i_frame_height,
	input  logic [sys_ctrl_pkg::DIM_W-1:0] i_vset,
	input  logic [sys_ctrl_pkg::DIM_W-1:0] i_hset,
	input  logic                           i_freescale,
	input  sys_ctrl_pkg::ar_word_u         i_arx,
	input  sys_ctrl_pkg::ar_word_u         i_ary,
	input  sys_ctrl_pkg::ar_word_u         i_arc1x,
	input  sys_ctrl_pkg::ar_word_u         i_arc1y,
	input  sys_ctrl_pkg::ar_word_u         i_arc2x,
	input  sys_ctrl_pkg::ar_word_u         i_arc2y,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_hdmi_width,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_hdmi_height,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_hmin,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_hmax,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_vmin,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_vmax
);
	import sys_ctrl_pkg::*;

	localparam logic [2:0] ST_SEL    = 3'd0;
	localparam logic [2:0] ST_MUL_W  = 3'd1;
	localparam logic [2:0] ST_WAIT_W = 3'd2;
	localparam logic [2:0] ST_MUL_H  = 3'd3;
	localparam logic [2:0] ST_WAIT_H = 3'd4;
	localparam logic [2:0] ST_CLAMP  = 3'd5;
	localparam logic [2:0] ST_POS    = 3'd6;

	logic [2:0]       state;
	logic [DIM_W-1:0] out_w, out_h;
	logic [DIM_W-1:0] sel_x, sel_y;
	logic             sel_direct;
	logic [DIM_W-1:0] wcalc, hcalc;
	logic [DIM_W-1:0] win_w, win_h;
	logic [DIM_W-1:0] h_half, v_half;
	logic             md_start, md_busy;
	logic [MD_W-1:0]  md_mul1, md_mul2, md_div, md_res;

	assign o_hdmi_width  = out_w;
	assign o_hdmi_height = out_h;
	assign h_half        = (i_frame_width - win_w) >> 1;
	assign v_half        = (i_frame_height - win_h) >> 1;

	umuldiv #(
		.MD_W(MD_W)
	) u_umuldiv (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_start(md_start),
		.i_mul1 (md_mul1),
		.i_mul2 (md_mul2),
		.i_div  (md_div),
		.o_busy (md_busy),
		.o_res  (md_res)
	);

	// Output size clamps and ratio selection
	always_ff @(posedge clk_sys) begin
		out_w <= (i_hset != '0 && i_hset < i_frame_width) ? i_hset : i_frame_width;
		out_h <= (i_vset != '0 && i_vset < i_frame_height) ? i_vset : i_frame_height;
		if (i_ary.index == '0) begin
			if (i_arx.index == AR_W'(1)) begin
				sel_x      <= i_arc1x.ratio.value;
				sel_y      <= i_arc1y.ratio.value;
				sel_direct <= i_arc1x.ratio.direct | i_arc1y.ratio.direct;
			end else if (i_arx.index == AR_W'(2)) begin
				sel_x      <= i_arc2x.ratio.value;
				sel_y      <= i_arc2y.ratio.value;
				sel_direct <= i_arc2x.ratio.direct | i_arc2y.ratio.direct;
			end else begin
				sel_x      <= '0;
				sel_y      <= '0;
				sel_direct <= 1'b0;
			end
		end else begin
			sel_x      <= i_arx.ratio.value;
			sel_y      <= i_ary.ratio.value;
			sel_direct <= i_arx.ratio.direct | i_ary.ratio.direct;
		end
	end

	////////////////////////////////
	// Window FSM
	////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= ST_SEL;
			md_start <= 1'b0;
		end else begin
			md_start <= 1'b0;
			case (state)
				ST_SEL: begin
					if (i_freescale || sel_x == '0 || sel_y == '0) begin
						wcalc <= out_w;
						hcalc <= out_h;
						state <= ST_CLAMP;
					end else if (sel_direct) begin
						wcalc <= sel_x;
						hcalc <= sel_y;
						state <= ST_CLAMP;
					end else begin
						state <= ST_MUL_W;
					end
				end
				// Width from height times x over y
				ST_MUL_W: begin
					md_mul1  <= MD_W'(out_h);
					md_mul2  <= MD_W'(sel_x);
					md_div   <= MD_W'(sel_y);
					md_start <= 1'b1;
					state    <= ST_WAIT_W;
				end
				ST_WAIT_W: begin
					if (!md_start && !md_busy) begin
						wcalc <= DIM_W'(md_res);
						state <= ST_MUL_H;
					end
				end
				ST_MUL_H: begin
					md_mul1  <= MD_W'(out_w);
					md_mul2  <= MD_W'(sel_y);
					md_div   <= MD_W'(sel_x);
					md_start <= 1'b1;
					state    <= ST_WAIT_H;
				end
				ST_WAIT_H: begin
					if (!md_start && !md_busy) begin
						hcalc <= DIM_W'(md_res);
						state <= ST_CLAMP;
					end
				end
				ST_CLAMP: begin
					win_w <= (wcalc > out_w) ? out_w : wcalc;
					win_h <= (hcalc > out_h) ? out_h : hcalc;
					state <= ST_POS;
				end
				// Centre the window in the frame
				ST_POS: begin
					o_hmin <= h_half;
					o_hmax <= h_half + win_w - 1'b1;
					o_vmin <= v_half;
					o_vmax <= v_half + win_h - 1'b1;
					state  <= ST_SEL;
				end
				default: state <= ST_SEL;
			endcase
		end
	end

endmodule

// File: hdl/sync_polarity_fix.sv
// Sync polarity correction
`timescale 1ns/1ps

module sync_polarity_fix (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);
	// Wide enough for a full frame at HD rates
	localparam int CNT_W = 24;

	logic             s1, s2;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;
	logic             pol;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			if (s1 != s2) begin
				cnt <= '0;
			end else if (~&cnt) begin
				cnt <= cnt + 1'b1;
			end
			// Phase lengths captured as each phase ends
			if (s1 & ~s2) begin
				low_len <= cnt;
			end
			if (~s1 & s2) begin
				high_len <= cnt;
			end
			pol <= high_len > low_len;
		end
	end

endmodule

// File: hdl/csync_gen.sv
// Composite sync generator
`timescale 1ns/1ps

module csync_gen (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hsync,
	input  logic i_vsync,
	output logic o_csync
);
	logic        prev_hs;
	logic        csync_hs;
	logic        csync_vs;
	logic [15:0] h_cnt;
	logic [15:0] line_len;
	logic [15:0] hs_len;

	assign o_csync = csync_vs ^ csync_hs;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			csync_hs <= 1'b0;
			csync_vs <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			prev_hs <= i_hsync;
			if (prev_hs != i_hsync) begin
				h_cnt <= '0;
				// Low phase minus pulse width marks where the shifted pulse starts
				if (i_hsync) begin
					line_len <= h_cnt - hs_len;
				end else begin
					hs_len <= h_cnt;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end

			if (!i_vsync) begin
				csync_hs <= i_hsync;
			end else if (prev_hs != i_hsync && i_hsync) begin
				csync_hs <= 1'b0;
			end else if (h_cnt == line_len) begin
				// Pulse moved to end of line during VSYNC
				csync_hs <= 1'b1;
			end
			csync_vs <= i_vsync;
		end
	end

endmodule

// File: hdl/sys_ctrl_top.sv
// System control top level
`timescale 1ns/1ps

module sys_ctrl_top #(
	parameter logic [7:0] CORE_TYPE = 8'hA4,
	parameter int         MD_W      = sys_ctrl_pkg::DIM_W
) (
	input  logic                           clk_sys,
	input  logic                           resetd,
	input  logic [31:0]                    i_gp_out,
	input  logic                           i_io_wait,
	input  logic [2:0]                     i_led_status,
	input  sys_ctrl_pkg::ar_word_u         i_arx,
	input  sys_ctrl_pkg::ar_word_u         i_ary,
	input  logic                           i_hs_raw,
	input  logic                           i_vs_raw,
	output logic [31:0]                    o_gp_in,
	output logic [15:0]                    o_cfg,
	output logic [7:0]                     o_led,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_hdmi_width,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_hdmi_height,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_hmin,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_hmax,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_vmin,
	output logic [sys_ctrl_pkg::DIM_W-1:0] o_vmax,
	output logic                           o_hs_fix,
	output logic                           o_vs_fix,
	output logic                           o_csync
);
	import sys_ctrl_pkg::*;

	logic             io_strobe, io_uio;
	logic [15:0]      io_din;
	logic [DIM_W-1:0] frame_width, frame_height;
	logic [DIM_W-1:0] vset, hset;
	logic             freescale;
	ar_word_u         arc1x, arc1y, arc2x, arc2y;

	////////////////////////////////
	// Host side
	////////////////////////////////
	hps_strobe_sync #(
		.CORE_TYPE(CORE_TYPE)
	) u_hps_strobe_sync (
		.clk_sys(clk_sys), .resetd(resetd), .i_gp_out(i_gp_out), .i_io_wait(i_io_wait),
		.o_gp_in(o_gp_in), .o_io_strobe(io_strobe), .o_io_uio(io_uio), .o_io_din(io_din)
	);

	uio_cmd_decoder u_uio_cmd_decoder (
		.clk_sys(clk_sys), .resetd(resetd), .i_io_strobe(io_strobe), .i_io_uio(io_uio),
		.i_io_din(io_din), .i_led_status(i_led_status), .o_cfg(o_cfg), .o_led(o_led),
		.o_frame_width(frame_width), .o_frame_height(frame_height),
		.o_vset(vset), .o_hset(hset), .o_freescale(freescale),
		.o_arc1x(arc1x), .o_arc1y(arc1y), .o_arc2x(arc2x), .o_arc2y(arc2y)
	);

	ar_window_calc #(
		.MD_W(MD_W)
	) u_ar_window_calc (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_frame_width(frame_width), .i_frame_height(frame_height),
		.i_vset(vset), .i_hset(hset), .i_freescale(freescale),
		.i_arx(i_arx), .i_ary(i_ary),
		.i_arc1x(arc1x), .i_arc1y(arc1y), .i_arc2x(arc2x), .i_arc2y(arc2y),
		.o_hdmi_width(o_hdmi_width), .o_hdmi_height(o_hdmi_height),
		.o_hmin(o_hmin), .o_hmax(o_hmax), .o_vmin(o_vmin), .o_vmax(o_vmax)
	);

	// Video sync path
	sync_polarity_fix u_hs_fix (
		.clk_sys(clk_sys), .resetd(resetd), .i_sync(i_hs_raw), .o_sync(o_hs_fix)
	);

	sync_polarity_fix u_vs_fix (
		.clk_sys(clk_sys), .resetd(resetd), .i_sync(i_vs_raw), .o_sync(o_vs_fix)
	);

	csync_gen u_csync_gen (
		.clk_sys(clk_sys), .resetd(resetd), .i_hsync(o_hs_fix), .i_vsync(o_vs_fix),
		.o_csync(o_csync)
	);

endmodule

// File: verif/sys_ctrl_tb.sv
// System control testbench
`timescale 1ns/1ps

module sys_ctrl_tb;
	import sys_ctrl_pkg::*;

	localparam int NROWS       = 16;
	localparam int CYCLE_LIMIT = 200 * NROWS + 2000;
	localparam int SEL_CFG     = 0;
	localparam int SEL_LED     = 1;
	localparam int SEL_WIN     = 2;
	localparam int HS_PERIOD   = 40;
	localparam int HS_LOW      = 4;
	localparam int VS_PERIOD   = 400;
	localparam int VS_LOW      = 40;
	localparam int SYNC_CYCLES = 1300;
	localparam int SYNC_SETTLE = 2 * VS_PERIOD + VS_LOW + 8;
	localparam logic [12:0] DIRECT = 13'h1000;

	logic        clk_sys;
	logic        resetd;
	logic [31:0] i_gp_out;
	logic        i_io_wait;
	logic [2:0]  i_led_status;
	logic [12:0] i_arx, i_ary;
	logic        i_hs_raw, i_vs_raw;
	logic [31:0] o_gp_in;
	logic [15:0] o_cfg;
	logic [7:0]  o_led;
	logic [11:0] o_hdmi_width, o_hdmi_height, o_hmin, o_hmax, o_vmin, o_vmax;
	logic        o_hs_fix, o_vs_fix, o_csync;

	// Stimulus table, one row per test
	string       row_name   [NROWS];
	logic [7:0]  row_cmd    [NROWS];
	logic        row_sel_on [NROWS];
	int          row_nw     [NROWS];
	logic [15:0] row_d      [NROWS][5];
	logic [12:0] row_arx    [NROWS];
	logic [12:0] row_ary    [NROWS];
	logic [2:0]  row_st     [NROWS];
	int          row_osel   [NROWS];
	logic [71:0] row_exp    [NROWS];

	int rows, tests, checks, errors, cycles;

	// Reference copy of the decoder registers
	logic [15:0] m_cfg;
	logic [7:0]  m_ovr, m_state;
	logic [11:0] m_w, m_h, m_vset, m_hset;
	logic        m_fs;
	logic [12:0] m_arc [4];

	sys_ctrl_top u_sys_ctrl_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [71:0] exp, input logic [71:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int e0);
		tests++;
		$display("test %-20s %0d errors", name, errors - e0);
	endtask

	////////////////////////////////
	// Reference model
	////////////////////////////////
	function automatic logic [7:0] led_model(input logic [2:0] st);
		logic [7:0] base;
		logic [7:0] led;
		// Power at bit 4, disk at bit 2, user at bit 0
		base    = '0;
		base[4] = st[2];
		base[2] = st[1];
		base[0] = st[0];
		for (int i = 0; i < 8; i++) begin
			led[i] = m_ovr[i] ? m_state[i] : base[i];
		end
		return led;
	endfunction

	function automatic logic [71:0] window_model(input logic [12:0] arx, input logic [12:0] ary);
		int  fw, fh, ow, oh, x, y, ww, wh, hmin, vmin;
		logic dir;
		fw = m_w;
		fh = m_h;
		ow = (m_hset != 0 && m_hset < m_w) ? m_hset : m_w;
		oh = (m_vset != 0 && m_vset < m_h) ? m_vset : m_h;
		x = 0;
		y = 0;
		dir = 1'b0;
		// Zero partner word turns arx into a custom ratio index
		if (ary == 13'd0) begin
			if (arx == 13'd1 || arx == 13'd2) begin
				x = m_arc[2 * (arx - 1)][11:0];
				y = m_arc[2 * (arx - 1) + 1][11:0];
				dir = m_arc[2 * (arx - 1)][12] | m_arc[2 * (arx - 1) + 1][12];
			end
		end else begin
			x = arx[11:0];
			y = ary[11:0];
			dir = arx[12] | ary[12];
		end
		if (m_fs || x == 0 || y == 0) begin
			ww = ow;
			wh = oh;
		end else if (dir) begin
			ww = x;
			wh = y;
		end else begin
			ww = oh * x / y;
			wh = ow * y / x;
		end
		if (ww > ow) begin
			ww = ow;
		end
		if (wh > oh) begin
			wh = oh;
		end
		hmin = (fw - ww) / 2;
		vmin = (fh - wh) / 2;
		return {12'(ow), 12'(oh), 12'(hmin), 12'(hmin + ww - 1), 12'(vmin), 12'(vmin + wh - 1)};
	endfunction

	task automatic model_update(input int r);
		case (row_cmd[r])
			CMD_CFG: m_cfg = row_d[r][0];
			CMD_TIMING: begin
				m_w = row_d[r][0][11:0];
				m_h = row_d[r][4][11:0];
			end
			CMD_LED: {m_ovr, m_state} = row_d[r][0];
			CMD_VSET: m_vset = row_d[r][0][11:0];
			CMD_HSET: begin
				m_fs   = row_d[r][0][15];
				m_hset = row_d[r][0][11:0];
			end
			CMD_AR_CUSTOM: begin
				for (int i = 0; i < 4; i++) begin
					m_arc[i] = row_d[r][i][12:0];
				end
			end
			default: ;
		endcase
	endtask

	task automatic add_row(input string name, input logic [7:0] cmd, input logic sel_on,
			input int nw, input logic [79:0] words, input logic [12:0] arx,
			input logic [12:0] ary, input logic [2:0] st, input int osel);
		row_name[rows]   = name;
		row_cmd[rows]    = cmd;
		row_sel_on[rows] = sel_on;
		row_nw[rows]     = nw;
		row_arx[rows]    = arx;
		row_ary[rows]    = ary;
		row_st[rows]     = st;
		row_osel[rows]   = osel;
		for (int i = 0; i < 5; i++) begin
			row_d[rows][i] = words[79 - 16 * i -: 16];
		end
		if (sel_on && cmd != 8'd0) begin
			model_update(rows);
		end
		case (osel)
			SEL_CFG: row_exp[rows] = {56'd0, m_cfg};
			SEL_LED: row_exp[rows] = {64'd0, led_model(st)};
			default: row_exp[rows] = window_model(arx, ary);
		endcase
		rows++;
	endtask

	task automatic build_table();
		logic [15:0] cfg_word;
		cfg_word = 16'($urandom);
		add_row("cfg_random", CMD_CFG, 1, 1, {cfg_word, 64'd0}, 13'd4, 13'd3, 3'd0, SEL_CFG);
		add_row("cfg_no_select", CMD_CFG, 0, 1, {~cfg_word, 64'd0}, 13'd4, 13'd3, 3'd0, SEL_CFG);
		add_row("led_random_a", CMD_LED, 1, 1, {16'($urandom), 64'd0}, 13'd4, 13'd3,
			3'($urandom), SEL_LED);
		add_row("led_random_b", CMD_LED, 1, 1, {16'($urandom), 64'd0}, 13'd4, 13'd3,
			3'($urandom), SEL_LED);
		// Only words 0 and 4 of the timing burst are kept
		add_row("win_720p_4_3", CMD_TIMING, 1, 5, {16'd1280, 16'd1650, 16'd110, 16'd40, 16'd720},
			13'd4, 13'd3, 3'd0, SEL_WIN);
		add_row("win_21_9", 8'd0, 1, 0, 80'd0, 13'd21, 13'd9, 3'd0, SEL_WIN);
		add_row("win_direct", 8'd0, 1, 0, 80'd0, DIRECT | 13'd800, 13'd600, 3'd0, SEL_WIN);
		add_row("win_zero", 8'd0, 1, 0, 80'd0, 13'd0, 13'd0, 3'd0, SEL_WIN);
		add_row("win_1080p_5_4", CMD_TIMING, 1, 5, {16'd1920, 16'd2200, 16'd88, 16'd44, 16'd1080},
			13'd5, 13'd4, 3'd0, SEL_WIN);
		add_row("vset_below", CMD_VSET, 1, 1, {16'd900, 64'd0}, 13'd4, 13'd3, 3'd0, SEL_WIN);
		add_row("hset_above", CMD_HSET, 1, 1, {16'd2000, 64'd0}, 13'd16, 13'd9, 3'd0, SEL_WIN);
		add_row("freescale", CMD_HSET, 1, 1, {16'h8000 | 16'd1600, 64'd0}, 13'd4, 13'd3, 3'd0,
			SEL_WIN);
		add_row("hset_clear", CMD_HSET, 1, 1, {16'd0, 64'd0}, 13'd7, 13'd3, 3'd0, SEL_WIN);
		add_row("custom_idx1", CMD_AR_CUSTOM, 1, 4, {16'd16, 16'd10, 16'h1000 | 16'd1024,
			16'd768, 16'd0}, 13'd1, 13'd0, 3'd0, SEL_WIN);
		add_row("custom_idx2", 8'd0, 1, 0, 80'd0, 13'd2, 13'd0, 3'd0, SEL_WIN);
		add_row("custom_idx3", 8'd0, 1, 0, 80'd0, 13'd3, 13'd0, 3'd0, SEL_WIN);
	endtask

	////////////////////////////////
	// Host bus
	////////////////////////////////
	task automatic drive_host(input logic [15:0] data, input logic sel, input logic io_clk);
		@(posedge clk_sys);
		#1;
		// Ready, ss2, ss1 and ss0, io clock, data
		i_gp_out = {1'b1, 10'd0, sel, 2'b00, io_clk, 1'b0, data};
	endtask

	task automatic wait_ack(input logic level);
		@(negedge clk_sys);
		while (o_gp_in[17] !== level) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic host_xfer(input logic [15:0] data, input logic sel);
		drive_host(data, sel, 1'b0);
		drive_host(data, sel, 1'b1);
		wait_ack(1'b1);
		drive_host(data, sel, 1'b0);
		wait_ack(1'b0);
	endtask

	task automatic send_cmd(input int r);
		host_xfer({8'd0, row_cmd[r]}, row_sel_on[r]);
		for (int i = 0; i < row_nw[r]; i++) begin
			host_xfer(row_d[r][i], row_sel_on[r]);
		end
		drive_host(16'd0, 1'b0, 1'b0);
	endtask

	task automatic apply_row(input int r);
		logic [71:0] act;
		int          e0;
		e0 = errors;
		@(posedge clk_sys);
		#1;
		i_arx        = row_arx[r];
		i_ary        = row_ary[r];
		i_led_status = row_st[r];
		if (row_cmd[r] != 8'd0) begin
			send_cmd(r);
		end
		// Window recompute settles well inside this
		repeat (100) @(posedge clk_sys);
		@(negedge clk_sys);
		case (row_osel[r])
			SEL_CFG: act = {56'd0, o_cfg};
			SEL_LED: act = {64'd0, o_led};
			default: act = {o_hdmi_width, o_hdmi_height, o_hmin, o_hmax, o_vmin, o_vmax};
		endcase
		check_val(row_name[r], row_exp[r], act);
		report_test(row_name[r], e0);
	endtask

	task automatic greeting_test();
		int e0;
		e0 = errors;
		@(negedge clk_sys);
		check_val("greeting_magic", 72'h5CA623A4, o_gp_in);
		drive_host(16'd0, 1'b0, 1'b0);
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_val("greeting_status", 72'h0004_0000, o_gp_in);
		repeat (2) begin
			drive_host(16'd0, 1'b0, 1'b1);
			wait_ack(1'b1);
			drive_host(16'd0, 1'b0, 1'b0);
			wait_ack(1'b0);
		end
		// Core wait holds the ack after the strobe
		drive_host(16'd0, 1'b0, 1'b1);
		i_io_wait = 1'b1;
		repeat (12) @(negedge clk_sys);
		check_val("ack_hold_wait", 72'd0, o_gp_in[17]);
		@(posedge clk_sys);
		#1;
		i_io_wait = 1'b0;
		wait_ack(1'b1);
		drive_host(16'd0, 1'b0, 1'b0);
		wait_ack(1'b0);
		report_test("greeting_handshake", e0);
	endtask

	task automatic sync_test();
		int   e0;
		logic prev_hs, prev_vs;
		e0 = errors;
		prev_hs = 1'b0;
		prev_vs = 1'b1;
		for (int n = 0; n < SYNC_CYCLES; n++) begin
			@(posedge clk_sys);
			#1;
			i_hs_raw = (n % HS_PERIOD) >= HS_LOW;
			i_vs_raw = (n % VS_PERIOD) >= VS_LOW;
			@(negedge clk_sys);
			if (n >= SYNC_SETTLE) begin
				check_val("sync_hs_fix", !i_hs_raw, o_hs_fix);
				check_val("sync_vs_fix", !i_vs_raw, o_vs_fix);
				if (!prev_vs) begin
					check_val("sync_csync", prev_hs, o_csync);
				end
			end
			// Corrected syncs are the inverted active low inputs
			prev_hs = !i_hs_raw;
			prev_vs = !i_vs_raw;
		end
		report_test("sync_path", e0);
	endtask

	initial begin
		void'($urandom(32'h56f4));
		resetd       = 1'b1;
		i_gp_out     = '0;
		i_io_wait    = 1'b0;
		i_led_status = '0;
		i_arx        = '0;
		i_ary        = '0;
		i_hs_raw     = 1'b1;
		i_vs_raw     = 1'b1;
		rows         = 0;
		tests        = 0;
		checks       = 0;
		errors       = 0;
		cycles       = 0;
		m_cfg        = '0;
		m_ovr        = '0;
		m_state      = '0;
		m_w          = 12'd1920;
		m_h          = 12'd1080;
		m_vset       = '0;
		m_hset       = '0;
		m_fs         = 1'b0;
		for (int i = 0; i < 4; i++) begin
			m_arc[i] = '0;
		end
		build_table();
		repeat (16) @(posedge clk_sys);
		#1;
		resetd = 1'b0;
		greeting_test();
		for (int r = 0; r < rows; r++) begin
			apply_row(r);
		end
		sync_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: sys_ctrl_top.f
hdl/sys_ctrl_pkg.sv
hdl/hps_strobe_sync.sv
hdl/uio_cmd_decoder.sv
hdl/umuldiv.sv
hdl/ar_window_calc.sv
hdl/sync_polarity_fix.sv
hdl/csync_gen.sv
hdl/sys_ctrl_top.sv
verif/sys_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the system control testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module sys_ctrl_tb -f sys_ctrl_top.f -o sim_sys_ctrl \
	&& ./obj_dir/sim_sys_ctrl | tee sim.log \
	|| { echo "Build or simulation error"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
